//--- dcache_hit.f
dcache_hit_pkg.sv
dcache_store_capture.sv
dcache_mem_fsm.sv
dcache_read_select.sv
dcache_hit.sv
tb_dcache_hit.sv

//--- tb_dcache_hit.sv
/*
 * testbench for the data cache hit stage
 * seeded random core, write buffer and BIU traffic against a cycle model
 */

`default_nettype none

module tb_dcache_hit;
  import dcache_hit_pkg::*;

  localparam int NUM_CYCLES = 2000;
  localparam int MAX_CYCLES = 4 * NUM_CYCLES;

  logic clk_i, rst_ni, flush_i, req_i, wreq_i, is_cacheable_i, cache_hit_i, way_dirty_i;
  logic writebuffer_ack_i, biucmd_ack_i, biucmd_noncacheable_ack_i;
  logic biu_stb_ack_i, biu_ack_i, biu_err_i, in_biubuffer_i;
  adr_t      adr_i, biu_adro_i;
  be_t       be_i;
  word_t     d_i, biu_q_i;
  ways_t     ways_hit_i;
  line_t     cache_line_i, biubuffer_i;
  inflight_t inflight_cnt_i;

  logic stall_o, armed_o, filling_o, ack_o, err_o, writebuffer_we_o, biucmd_noncacheable_req_o;
  word_t     q_o, writebuffer_data_o;
  idx_t      idx_o, writebuffer_idx_o;
  tag_t      core_tag_o;
  dat_offs_t writebuffer_offs_o;
  be_t       writebuffer_be_o;
  ways_t     writebuffer_ways_hit_o;
  biucmd_t   biucmd_o;

  // reference model
  memfsm_state_t m_state;
  logic e_armed, e_filling, e_ack, e_err, e_we;
  biucmd_t   e_cmd;
  word_t     e_q, e_wb_data;
  idx_t      e_wb_idx;
  dat_offs_t e_wb_offs;
  be_t       e_wb_be;
  ways_t     e_wb_ways;

  // core hold and BIU responder
  logic   held, nc_open, fill_pending;
  int     fill_cnt, nc_cnt;
  integer seed = 32'hebbf6db9;
  int     errors = 0;
  int     cycles = 0;

  dcache_hit dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // timeout
  //////////////////////////////

  always @(posedge clk_i) cycles <= cycles + 1;

  initial
  begin
    wait (cycles >= MAX_CYCLES);
    $display("timeout: stimulus still running after %0d cycles", cycles);
    $display("Errors found");
    $finish;
  end

  task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic drive_inputs();
    logic [3:0] kind;
    logic       fill_ack;
    logic       nc_ack;
    fill_ack = 1'b0;
    nc_ack   = 1'b0;
    // new request only once the previous one got past stall
    if (!held)
    begin
      kind           = $random(seed) & 15;
      req_i          = (kind >= 4);
      is_cacheable_i = (kind < 12);
      wreq_i         = (kind >= 4) && (kind < 12) && kind[0];
      cache_hit_i    = ($random(seed) & 3) != 0;
      way_dirty_i    = $random(seed) & 1;
      adr_i          = $random(seed);
      d_i            = $random(seed);
      be_i           = $random(seed);
      ways_hit_i     = $random(seed);
    end
    cache_line_i      = {$random(seed), $random(seed), $random(seed), $random(seed)};
    biubuffer_i       = {$random(seed), $random(seed), $random(seed), $random(seed)};
    in_biubuffer_i    = $random(seed) & 1;
    biu_q_i           = $random(seed);
    biu_err_i         = ($random(seed) & 15) == 0;
    flush_i           = ($random(seed) & 31) == 0;
    writebuffer_ack_i = $random(seed) & 1;
    // fill or eviction acked after 1 to 4 cycles
    if (m_state == EVICT || m_state == WAIT4BIUCMD0)
    begin
      if (!fill_pending)
      begin
        fill_pending = 1'b1;
        fill_cnt     = 1 + ($unsigned($random(seed)) % 4);
      end
      fill_cnt--;
      fill_ack = (fill_cnt == 0);
      if (fill_ack)
        fill_pending = 1'b0;
    end
    else
      fill_pending = 1'b0;
    // one non-cacheable transfer at a time
    inflight_cnt_i = inflight_t'(nc_open);
    if (nc_open)
    begin
      nc_cnt--;
      nc_ack = (nc_cnt == 0);
    end
    biu_stb_ack_i             = !nc_open && (($random(seed) & 1) != 0);
    biucmd_ack_i              = fill_ack;
    biucmd_noncacheable_ack_i = nc_ack;
    biu_ack_i                 = fill_ack | nc_ack;
    biu_adro_i                = (fill_ack | nc_ack) ? adr_i : adr_t'($random(seed));
  endtask

  //////////////////////////////
  // model and checks
  //////////////////////////////

  // combinational outputs, inputs settled
  task automatic inspect_comb_outputs();
    logic match;
    match = (biu_adro_i[31:2] == adr_i[31:2]);
    held  = stall_o;
    check_eq(idx_o, adr_i[9:4], "idx_o");
    check_eq(core_tag_o, adr_i[31:10], "core_tag_o");
    check_eq(biucmd_noncacheable_req_o,
             (m_state == ARMED) && req_i && !is_cacheable_i && !flush_i,
             "biucmd_noncacheable_req_o");
    if (!flush_i)
    begin
      case (m_state)
        ARMED:
          if (req_i)
            check_eq(stall_o, is_cacheable_i ? !cache_hit_i : !biu_stb_ack_i, "stall_o armed");
        WAIT4BIUCMD0:
          check_eq(stall_o, !(req_i && ((biu_ack_i && match) || cache_hit_i)), "stall_o fill");
        RECOVER:
          check_eq(stall_o, !(req_i && cache_hit_i), "stall_o recover");
        default:
          ;
      endcase
    end
  endtask

  task automatic verify_reg_outputs();
    check_eq(armed_o, e_armed, "armed_o");
    check_eq(filling_o, e_filling, "filling_o");
    check_eq(biucmd_o, e_cmd, "biucmd_o");
    check_eq(ack_o, e_ack, "ack_o");
    check_eq(err_o, e_err, "err_o");
    check_eq(writebuffer_we_o, e_we, "writebuffer_we_o");
    if (e_ack)
      check_eq(q_o, e_q, "q_o");
    if (e_we)
    begin
      check_eq(writebuffer_idx_o, e_wb_idx, "writebuffer_idx_o");
      check_eq(writebuffer_offs_o, e_wb_offs, "writebuffer_offs_o");
      check_eq(writebuffer_data_o, e_wb_data, "writebuffer_data_o");
      check_eq(writebuffer_be_o, e_wb_be, "writebuffer_be_o");
      check_eq(writebuffer_ways_hit_o, e_wb_ways, "writebuffer_ways_hit_o");
    end
  endtask

  // next state of the model from the inputs of this cycle
  task automatic update_model();
    logic  match, cache_ack, fill_ack, miss, nc_req, use_cache;
    line_t line;
    match     = (biu_adro_i[31:2] == adr_i[31:2]);
    cache_ack = req_i && is_cacheable_i && cache_hit_i && !flush_i;
    fill_ack  = (req_i && biu_ack_i && match && !flush_i) || cache_ack;
    miss      = req_i && is_cacheable_i && !cache_hit_i && !flush_i;
    nc_req    = req_i && !is_cacheable_i && !flush_i;
    // word source: hit decides during a fill, cacheable otherwise
    use_cache = (m_state == WAIT4BIUCMD0) ? cache_hit_i : is_cacheable_i;
    line      = in_biubuffer_i ? biubuffer_i : cache_line_i;
    e_q       = use_cache ? line[32*adr_i[3:2] +: 32] : biu_q_i;
    e_err     = biu_err_i;
    if (wreq_i && is_cacheable_i && cache_hit_i)
    begin
      e_wb_idx  = adr_i[9:4];
      e_wb_offs = adr_i[3:2];
      e_wb_data = d_i;
      e_wb_be   = be_i;
      e_wb_ways = ways_hit_i;
    end
    if (flush_i)
      e_we = 1'b0;
    else if (wreq_i && is_cacheable_i && cache_hit_i)
      e_we = 1'b1;
    else if (writebuffer_ack_i)
      e_we = 1'b0;
    // responder bookkeeping
    if (biucmd_noncacheable_ack_i)
      nc_open = 1'b0;
    if ((m_state == ARMED || m_state == NONCACHEABLE) && nc_req && biu_stb_ack_i)
    begin
      nc_open = 1'b1;
      nc_cnt  = 1 + ($unsigned($random(seed)) % 4);
    end
    case (m_state)
      ARMED:
      begin
        e_ack = cache_ack;
        if (nc_req)
        begin
          m_state = NONCACHEABLE;
          e_armed = 1'b0;
        end
        else if (miss)
        begin
          m_state   = way_dirty_i ? EVICT : WAIT4BIUCMD0;
          e_cmd     = BIUCMD_READWAY;
          e_armed   = 1'b0;
          e_filling = 1'b1;
        end
      end
      NONCACHEABLE:
      begin
        e_ack = biucmd_noncacheable_ack_i;
        if (flush_i || (biu_ack_i && (req_i ? is_cacheable_i : inflight_cnt_i == 1)))
        begin
          m_state = ARMED;
          e_armed = 1'b1;
        end
      end
      EVICT, WAIT4BIUCMD0:
      begin
        e_ack = (m_state == WAIT4BIUCMD0) && fill_ack;
        if (biucmd_ack_i || biu_err_i)
        begin
          // dirty victim written back in the recover cycle
          e_cmd     = (m_state == EVICT) ? BIUCMD_WRITEWAY : BIUCMD_NOP;
          e_filling = 1'b0;
          m_state   = RECOVER;
        end
      end
      default:
      begin
        e_ack   = cache_ack;
        e_cmd   = BIUCMD_NOP;
        e_armed = 1'b1;
        m_state = ARMED;
      end
    endcase
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    rst_ni = 1'b0;
    {flush_i, req_i, wreq_i, is_cacheable_i, cache_hit_i, way_dirty_i} = '0;
    {writebuffer_ack_i, biucmd_ack_i, biucmd_noncacheable_ack_i} = '0;
    {biu_stb_ack_i, biu_ack_i, biu_err_i, in_biubuffer_i} = '0;
    {adr_i, biu_adro_i, be_i, d_i, biu_q_i, ways_hit_i} = '0;
    {cache_line_i, biubuffer_i, inflight_cnt_i} = '0;
    m_state   = ARMED;
    e_armed   = 1'b1;
    e_filling = 1'b0;
    e_ack     = 1'b0;
    e_err     = 1'b0;
    e_we      = 1'b0;
    e_cmd     = BIUCMD_NOP;
    held         = 1'b0;
    nc_open      = 1'b0;
    fill_pending = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    // reset values
    verify_reg_outputs();
    rst_ni = 1'b1;
    for (int i = 0; i < NUM_CYCLES; i++)
    begin
      drive_inputs();
      #1;
      inspect_comb_outputs();
      @(posedge clk_i);
      update_model();
      @(negedge clk_i);
      verify_reg_outputs();
    end
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache_hit.sv
/*
 * data cache hit stage
 * joins store capture, memory FSM and read select
 */

`default_nettype none

module dcache_hit
  import dcache_hit_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,

  // pipe control
  output logic           stall_o,
  input  wire logic      flush_i,
  output logic           armed_o,
  output logic           filling_o,

  // core request
  input  wire logic      req_i,
  input  wire logic      wreq_i,
  input  wire adr_t      adr_i,
  input  wire be_t       be_i,
  input  wire word_t     d_i,
  input  wire logic      is_cacheable_i,
  output word_t          q_o,
  output logic           ack_o,
  output logic           err_o,

  // cache memories
  input  wire logic      cache_hit_i,
  input  wire ways_t     ways_hit_i,
  input  wire line_t     cache_line_i,
  input  wire logic      way_dirty_i,
  output idx_t           idx_o,
  output tag_t           core_tag_o,

  // write buffer
  output logic           writebuffer_we_o,
  input  wire logic      writebuffer_ack_i,
  output idx_t           writebuffer_idx_o,
  output dat_offs_t      writebuffer_offs_o,
  output word_t          writebuffer_data_o,
  output be_t            writebuffer_be_o,
  output ways_t          writebuffer_ways_hit_o,

  // BIU
  output biucmd_t        biucmd_o,
  input  wire logic      biucmd_ack_i,
  output logic           biucmd_noncacheable_req_o,
  input  wire logic      biucmd_noncacheable_ack_i,
  input  wire inflight_t inflight_cnt_i,
  input  wire word_t     biu_q_i,
  input  wire logic      biu_stb_ack_i,
  input  wire logic      biu_ack_i,
  input  wire logic      biu_err_i,
  input  wire adr_t      biu_adro_i,
  input  wire logic      in_biubuffer_i,
  input  wire line_t     biubuffer_i
);

  dat_offs_t dat_offset;
  logic      fill_wait;

  //////////////////////////////
  // input side
  //////////////////////////////

  dcache_store_capture u_store (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .flush_i                (flush_i),
    .wreq_i                 (wreq_i),
    .is_cacheable_i         (is_cacheable_i),
    .cache_hit_i            (cache_hit_i),
    .adr_i                  (adr_i),
    .d_i                    (d_i),
    .be_i                   (be_i),
    .ways_hit_i             (ways_hit_i),
    .writebuffer_ack_i      (writebuffer_ack_i),
    .idx_o                  (idx_o),
    .core_tag_o             (core_tag_o),
    .dat_offset_o           (dat_offset),
    .writebuffer_we_o       (writebuffer_we_o),
    .writebuffer_idx_o      (writebuffer_idx_o),
    .writebuffer_offs_o     (writebuffer_offs_o),
    .writebuffer_data_o     (writebuffer_data_o),
    .writebuffer_be_o       (writebuffer_be_o),
    .writebuffer_ways_hit_o (writebuffer_ways_hit_o)
  );

  //////////////////////////////
  // memory FSM
  //////////////////////////////

  dcache_mem_fsm u_fsm (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .flush_i                   (flush_i),
    .req_i                     (req_i),
    .is_cacheable_i            (is_cacheable_i),
    .cache_hit_i               (cache_hit_i),
    .way_dirty_i               (way_dirty_i),
    .biucmd_ack_i              (biucmd_ack_i),
    .biucmd_noncacheable_ack_i (biucmd_noncacheable_ack_i),
    .biu_ack_i                 (biu_ack_i),
    .biu_stb_ack_i             (biu_stb_ack_i),
    .biu_err_i                 (biu_err_i),
    .inflight_cnt_i            (inflight_cnt_i),
    .adr_i                     (adr_i),
    .biu_adro_i                (biu_adro_i),
    .stall_o                   (stall_o),
    .armed_o                   (armed_o),
    .filling_o                 (filling_o),
    .ack_o                     (ack_o),
    .fill_wait_o               (fill_wait),
    .biucmd_noncacheable_req_o (biucmd_noncacheable_req_o),
    .biucmd_o                  (biucmd_o)
  );

  //////////////////////////////
  // output side
  //////////////////////////////

  dcache_read_select u_read (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cache_line_i   (cache_line_i),
    .biubuffer_i    (biubuffer_i),
    .in_biubuffer_i (in_biubuffer_i),
    .cache_hit_i    (cache_hit_i),
    .is_cacheable_i (is_cacheable_i),
    .fill_wait_i    (fill_wait),
    .biu_err_i      (biu_err_i),
    .dat_offset_i   (dat_offset),
    .biu_q_i        (biu_q_i),
    .q_o            (q_o),
    .err_o          (err_o)
  );

endmodule

`default_nettype wire

//--- dcache_read_select.sv
/*
 * data cache read select
 * picks the addressed word from cache line, BIU buffer or BIU data
 */

`default_nettype none

module dcache_read_select
  import dcache_hit_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire line_t     cache_line_i,
  input  wire line_t     biubuffer_i,
  input  wire logic      in_biubuffer_i,
  input  wire logic      cache_hit_i,
  input  wire logic      is_cacheable_i,
  input  wire logic      fill_wait_i,
  input  wire logic      biu_err_i,
  input  wire dat_offs_t dat_offset_i,
  input  wire word_t     biu_q_i,

  output word_t          q_o,
  output logic           err_o
);

  line_t line_sel;
  word_t cache_q;
  logic  use_cache;

  //////////////////////////////
  // word select
  //////////////////////////////

  // fresh fill data wins over the stale line
  assign line_sel = in_biubuffer_i ? biubuffer_i : cache_line_i;
  assign cache_q  = line_sel[dat_offset_i*XLEN +: XLEN];

  // while filling only a real hit reads the cache
  assign use_cache = fill_wait_i ? cache_hit_i : is_cacheable_i;

  //////////////////////////////
  // output registers
  //////////////////////////////

  // read data, valid together with ack
  always_ff @(posedge clk_i)
  begin
    if (use_cache)
      q_o <= cache_q;
    else
      q_o <= biu_q_i;
  end

  // bus error one cycle late
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      err_o <= 1'b0;
    else
      err_o <= biu_err_i;
  end

endmodule

`default_nettype wire

//--- dcache_mem_fsm.sv
/*
 * data cache memory side FSM
 * way fill and eviction commands, non-cacheable tracking, stall and ack
 */

`default_nettype none

module dcache_mem_fsm
  import dcache_hit_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      flush_i,
  input  wire logic      req_i,
  input  wire logic      is_cacheable_i,
  input  wire logic      cache_hit_i,
  input  wire logic      way_dirty_i,
  input  wire logic      biucmd_ack_i,
  input  wire logic      biucmd_noncacheable_ack_i,
  input  wire logic      biu_ack_i,
  input  wire logic      biu_stb_ack_i,
  input  wire logic      biu_err_i,
  input  wire inflight_t inflight_cnt_i,
  input  wire adr_t      adr_i,
  input  wire adr_t      biu_adro_i,

  output logic           stall_o,
  output logic           armed_o,
  output logic           filling_o,
  output logic           ack_o,
  output logic           fill_wait_o,
  output logic           biucmd_noncacheable_req_o,
  output biucmd_t        biucmd_o
);

  memfsm_state_t state;

  logic adr_match;
  logic cache_ack;
  logic biu_cacheable_ack;
  logic miss;
  logic nc_done;

  //////////////////////////////
  // decode
  //////////////////////////////

  // BIU returns the word the core is waiting for
  assign adr_match = (biu_adro_i[PLEN-1:BURST_LSB] == adr_i[PLEN-1:BURST_LSB]);

  assign cache_ack         = req_i & is_cacheable_i & cache_hit_i & ~flush_i;
  // during a fill the word may come straight from the BIU
  assign biu_cacheable_ack = (req_i & biu_ack_i & adr_match & ~flush_i) | cache_ack;

  assign miss = req_i & is_cacheable_i & ~cache_hit_i & ~flush_i;

  // leave non-cacheable on flush, on last transfer done, or when a
  // cacheable request waits for the open transfer
  assign nc_done = flush_i |
                   (~req_i & (inflight_cnt_i == inflight_t'(1)) & biu_ack_i) |
                   (req_i & is_cacheable_i & biu_ack_i);

  assign fill_wait_o = (state == WAIT4BIUCMD0);

  //////////////////////////////
  // state machine
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state     <= ARMED;
      armed_o   <= 1'b1;
      filling_o <= 1'b0;
      biucmd_o  <= BIUCMD_NOP;
    end
    else
    begin
      case (state)
        ARMED:
        begin
          if (req_i && !is_cacheable_i && !flush_i)
          begin
            state   <= NONCACHEABLE;
            armed_o <= 1'b0;
          end
          else if (miss)
          begin
            // new line is read first, a dirty victim goes out afterwards
            state     <= way_dirty_i ? EVICT : WAIT4BIUCMD0;
            biucmd_o  <= BIUCMD_READWAY;
            armed_o   <= 1'b0;
            filling_o <= 1'b1;
          end
          else
            biucmd_o <= BIUCMD_NOP;
        end

        NONCACHEABLE:
        begin
          if (nc_done)
          begin
            state   <= ARMED;
            armed_o <= 1'b1;
          end
        end

        EVICT:
        begin
          if (biucmd_ack_i || biu_err_i)
          begin
            state     <= RECOVER;
            // write back the victim way
            biucmd_o  <= BIUCMD_WRITEWAY;
            filling_o <= 1'b0;
          end
        end

        WAIT4BIUCMD0:
        begin
          if (biucmd_ack_i || biu_err_i)
          begin
            state     <= RECOVER;
            biucmd_o  <= BIUCMD_NOP;
            filling_o <= 1'b0;
          end
        end

        RECOVER:
        begin
          // one cycle to reread tag and data memories
          state    <= ARMED;
          biucmd_o <= BIUCMD_NOP;
          armed_o  <= 1'b1;
        end

        default:
        begin
          state    <= ARMED;
          biucmd_o <= BIUCMD_NOP;
          armed_o  <= 1'b1;
        end
      endcase
    end
  end

  //////////////////////////////
  // BIU request and stall
  //////////////////////////////

  assign biucmd_noncacheable_req_o = (state == ARMED) & req_i & ~is_cacheable_i & ~flush_i;

  always_comb
  begin
    case (state)
      ARMED:
        stall_o = req_i & (is_cacheable_i ? ~cache_hit_i : ~biu_stb_ack_i);
      // idle core waits for outstanding transfers
      NONCACHEABLE:
        stall_o = ~req_i ? |inflight_cnt_i
                         : (is_cacheable_i ? ~biu_ack_i : ~biu_stb_ack_i);
      WAIT4BIUCMD0:
        stall_o = ~(biu_cacheable_ack | (req_i & cache_hit_i));
      RECOVER:
        stall_o = ~(req_i & cache_hit_i);
      default:
        stall_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // acknowledge
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ack_o <= 1'b0;
    else
    begin
      case (state)
        ARMED:        ack_o <= cache_ack;
        NONCACHEABLE: ack_o <= biucmd_noncacheable_ack_i;
        WAIT4BIUCMD0: ack_o <= biu_cacheable_ack;
        RECOVER:      ack_o <= cache_ack;
        default:      ack_o <= 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- dcache_store_capture.sv
/*
 * data cache store capture
 * splits the core address and holds a write hit for the write buffer
 */

`default_nettype none

module dcache_store_capture
  import dcache_hit_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      flush_i,
  input  wire logic      wreq_i,
  input  wire logic      is_cacheable_i,
  input  wire logic      cache_hit_i,
  input  wire adr_t      adr_i,
  input  wire word_t     d_i,
  input  wire be_t       be_i,
  input  wire ways_t     ways_hit_i,
  input  wire logic      writebuffer_ack_i,

  output idx_t           idx_o,
  output tag_t           core_tag_o,
  output dat_offs_t      dat_offset_o,
  output logic           writebuffer_we_o,
  output idx_t           writebuffer_idx_o,
  output dat_offs_t      writebuffer_offs_o,
  output word_t          writebuffer_data_o,
  output be_t            writebuffer_be_o,
  output ways_t          writebuffer_ways_hit_o
);

  logic write_hit;

  //////////////////////////////
  // address split
  //////////////////////////////

  // set index sits right above the block offset
  assign idx_o        = adr_i[BLK_OFFS_BITS +: IDX_BITS];
  assign core_tag_o   = adr_i[PLEN-1 -: TAG_BITS];
  // word within the block
  assign dat_offset_o = adr_i[BLK_OFFS_BITS-1 -: DAT_OFFS_BITS];

  assign write_hit = wreq_i & is_cacheable_i & cache_hit_i;

  //////////////////////////////
  // write buffer
  //////////////////////////////

  // strobe held until the buffer takes it, pipe flush kills it
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      writebuffer_we_o <= 1'b0;
    else if (flush_i)
      writebuffer_we_o <= 1'b0;
    else if (write_hit)
      writebuffer_we_o <= 1'b1;
    else if (writebuffer_ack_i)
      writebuffer_we_o <= 1'b0;
  end

  // payload of the write hit
  always_ff @(posedge clk_i)
  begin
    if (write_hit)
    begin
      writebuffer_idx_o      <= idx_o;
      writebuffer_offs_o     <= dat_offset_o;
      writebuffer_data_o     <= d_i;
      writebuffer_be_o       <= be_i;
      writebuffer_ways_hit_o <= ways_hit_i;
    end
  end

endmodule

`default_nettype wire

//--- dcache_hit_pkg.sv
/*
 * data cache hit stage definitions
 * fixed geometry, width types, BIU command and memory FSM encodings
 */

`default_nettype none

package dcache_hit_pkg;

  //////////////////////////////
  // geometry
  //////////////////////////////

  // 32-bit words, 16-byte blocks, 2 ways, 64 sets
  localparam int XLEN          = 32;
  localparam int PLEN          = 32;
  localparam int WAYS          = 2;
  localparam int BLK_BITS      = 128;
  localparam int BLK_OFFS_BITS = 4;
  localparam int DAT_OFFS_BITS = 2;
  // word granularity for BIU address compare
  localparam int BURST_LSB     = 2;
  localparam int IDX_BITS      = 6;
  localparam int TAG_BITS      = PLEN - IDX_BITS - BLK_OFFS_BITS;
  localparam int INFLIGHT_BITS = 2;

  //////////////////////////////
  // types
  //////////////////////////////

  typedef logic [XLEN-1:0]          word_t;
  typedef logic [XLEN/8-1:0]        be_t;
  typedef logic [PLEN-1:0]          adr_t;
  typedef logic [BLK_BITS-1:0]      line_t;
  typedef logic [IDX_BITS-1:0]      idx_t;
  typedef logic [TAG_BITS-1:0]      tag_t;
  typedef logic [DAT_OFFS_BITS-1:0] dat_offs_t;
  typedef logic [WAYS-1:0]          ways_t;
  typedef logic [INFLIGHT_BITS-1:0] inflight_t;

  // commands towards the BIU
  typedef enum logic [1:0] {
    BIUCMD_NOP      = 2'd0,
    BIUCMD_READWAY  = 2'd1,
    BIUCMD_WRITEWAY = 2'd2
  } biucmd_t;

  // memory side FSM
  typedef enum logic [2:0] {
    ARMED,
    NONCACHEABLE,
    EVICT,
    WAIT4BIUCMD0,
    RECOVER
  } memfsm_state_t;

endpackage

`default_nettype wire
